/* verilog/rs_syn_consts.svh */
// --------------------------------------------------
// Field and bank sizing for the RS syndrome generator
// --------------------------------------------------

`ifndef RS_SYN_CONSTS_SVH
`define RS_SYN_CONSTS_SVH

// Bits per GF(2^8) symbol
`define RS_SYM_WIDTH 8

// Number of syndromes, twice the correctable symbol count
`define RS_NUM_SYN 32

// Primitive polynomial x^8+x^7+x^2+x+1 with the x^8 term dropped
`define RS_FIELD_POLY 'h87

// Syndrome 0 is evaluated at alpha to this power
`define RS_FIRST_ROOT 1

`endif

/* verilog/gf_pkg.sv */
// --------------------------------------------------
// GF(2^8) symbol type and constant multiplier helpers
// --------------------------------------------------

`include "rs_syn_consts.svh"

package gf_pkg;

	// One field element in polynomial basis, bit 0 is the alpha^0 coefficient
	typedef logic [`RS_SYM_WIDTH-1:0] gf_sym_t;

	// Column b holds the image of basis bit b under a constant multiply
	typedef gf_sym_t [`RS_SYM_WIDTH-1:0] gf_matrix_t;

	// Number of nonzero field elements, alpha^GF_ORDER is one
	localparam int unsigned GF_ORDER = (1 << `RS_SYM_WIDTH) - 1;

	// --------------------------------------------------
	// Single step multiply by alpha
	// --------------------------------------------------

	// Shift up one power and fold x^8 back in with the field polynomial
	function automatic gf_sym_t gf_mul_alpha(input gf_sym_t a);
		gf_sym_t r;
		r = {a[`RS_SYM_WIDTH-2:0], 1'b0};
		if (a[`RS_SYM_WIDTH-1])
		begin
			r = r ^ gf_sym_t'(`RS_FIELD_POLY);
		end
		return r;
	endfunction

	// Repeated alpha steps, the power is reduced modulo the group order first
	function automatic gf_sym_t gf_mul_alpha_pow(input gf_sym_t a, input int unsigned k);
		gf_sym_t r;
		int unsigned steps;
		r = a;
		steps = k % GF_ORDER;
		for (int unsigned i = 0; i < steps; i++)
		begin
			r = gf_mul_alpha(r);
		end
		return r;
	endfunction

	// --------------------------------------------------
	// Constant multiplier matrix
	// --------------------------------------------------

	// Multiplying by alpha^k is linear over GF(2), so the product of any
	// symbol is the XOR of the columns selected by its set bits
	function automatic gf_matrix_t gf_const_matrix(input int unsigned k);
		gf_matrix_t m;
		gf_sym_t basis;
		for (int b = 0; b < `RS_SYM_WIDTH; b++)
		begin
			basis = gf_sym_t'(1) << b;
			m[b] = gf_mul_alpha_pow(basis, k);
		end
		return m;
	endfunction

endpackage

/* verilog/syn_pkg.sv */
// --------------------------------------------------
// Syndrome bank vector, cell operation and strobe decode
// --------------------------------------------------

`include "rs_syn_consts.svh"

package syn_pkg;

	// All syndromes side by side, syndrome 0 sits in the low word
	typedef gf_pkg::gf_sym_t [`RS_NUM_SYN-1:0] syn_bank_t;

	// What every cell does at the next rising edge
	typedef enum logic [1:0] {
		SYN_HOLD   = 2'b00,
		SYN_LOAD   = 2'b01,
		SYN_ACCUM  = 2'b10,
		SYN_ROTATE = 2'b11
	} syn_op_e;

	// --------------------------------------------------
	// Strobe priority
	// --------------------------------------------------

	// init wins over enable, enable wins over shift, nothing high holds
	function automatic syn_op_e syn_decode(
		input logic init,
		input logic enable,
		input logic shift
	);
		syn_op_e op;
		if (init)
			op = SYN_LOAD;
		else if (enable)
			op = SYN_ACCUM;
		else if (shift)
			op = SYN_ROTATE;
		else
			op = SYN_HOLD;
		return op;
	endfunction

endpackage

/* verilog/rs_syn_cell.sv */
// --------------------------------------------------
// One syndrome register with its constant root multiplier
// --------------------------------------------------

`timescale 1ns/1ps

`include "rs_syn_consts.svh"

module rs_syn_cell #(
	parameter int unsigned ROOT_POWER = `RS_FIRST_ROOT
) (
	input  logic              clk,
	input  logic              clrn,
	input  syn_pkg::syn_op_e  op,
	input  gf_pkg::gf_sym_t   u,
	input  gf_pkg::gf_sym_t   ring_in,
	output gf_pkg::gf_sym_t   syn_word
);

	// Multiply by alpha^ROOT_POWER, fixed when the design elaborates
	localparam gf_pkg::gf_matrix_t ROOT_MATRIX = gf_pkg::gf_const_matrix(ROOT_POWER);

	gf_pkg::gf_sym_t syn_reg;
	gf_pkg::gf_sym_t scaled;
	gf_pkg::gf_sym_t syn_next;

	// --------------------------------------------------
	// Constant multiplier
	// --------------------------------------------------

	// Each set bit of the register selects one matrix column. With the
	// matrix constant this reduces to a small XOR tree per output bit
	always_comb
	begin
		scaled = '0;
		for (int b = 0; b < `RS_SYM_WIDTH; b++)
		begin
			if (syn_reg[b])
			begin
				scaled = scaled ^ ROOT_MATRIX[b];
			end
		end
	end

	// --------------------------------------------------
	// Next value select
	// --------------------------------------------------

	// Horner step on accumulate: S <- S * alpha^k + u
	always_comb
	begin
		case (op)
			syn_pkg::SYN_LOAD:
				syn_next = u;
			syn_pkg::SYN_ACCUM:
				syn_next = scaled ^ u;
			syn_pkg::SYN_ROTATE:
				syn_next = ring_in;
			default:
				syn_next = syn_reg;
		endcase
	end

	always_ff @(posedge clk or negedge clrn)
	begin
		if (!clrn)
		begin
			syn_reg <= '0;
		end
		else
		begin
			syn_reg <= syn_next;
		end
	end

	assign syn_word = syn_reg;

	// --------------------------------------------------
	// Assertions
	// --------------------------------------------------

	// A load leaves the symbol sampled on that edge in the register
	load_takes_symbol: assert property (
		@(posedge clk) disable iff (!clrn)
		(op == syn_pkg::SYN_LOAD) |=> (syn_reg == $past(u))
	);

	// No operation means the register keeps its value
	hold_keeps_value: assert property (
		@(posedge clk) disable iff (!clrn)
		(op == syn_pkg::SYN_HOLD) |=> $stable(syn_reg)
	);

endmodule

/* verilog/rs_syndrome.sv */
// --------------------------------------------------
// RS syndrome generator top, strobe decode and cell ring
// --------------------------------------------------

`timescale 1ns/1ps

`include "rs_syn_consts.svh"

module rs_syndrome (
	input  logic               clk,
	input  logic               clrn,
	input  gf_pkg::gf_sym_t    u,
	input  logic               init,
	input  logic               enable,
	input  logic               shift,
	output syn_pkg::syn_bank_t syn
);

	// One decoded operation shared by the whole bank
	syn_pkg::syn_op_e op;

	// Rotate source for each cell, taken from the next cell up the ring
	gf_pkg::gf_sym_t ring [`RS_NUM_SYN];

	// --------------------------------------------------
	// Strobe decode
	// --------------------------------------------------

	assign op = syn_pkg::syn_decode(init, enable, shift);

	// --------------------------------------------------
	// Rotate ring
	// --------------------------------------------------

	// Word j is refilled from word j+1 and the top word wraps to word 0,
	// so a shift moves the bank one place toward index 0
	always_comb
	begin
		for (int j = 0; j < `RS_NUM_SYN; j++)
		begin
			ring[j] = syn[(j + 1) % `RS_NUM_SYN];
		end
	end

	// --------------------------------------------------
	// Syndrome cells
	// --------------------------------------------------

	// Cell j evaluates the received polynomial at alpha^(j+FIRST_ROOT)
	genvar j;
	generate
		for (j = 0; j < `RS_NUM_SYN; j++)
		begin : g_cell
			rs_syn_cell #(
				.ROOT_POWER(j + `RS_FIRST_ROOT)
			) cell_inst (
				.clk(clk),
				.clrn(clrn),
				.op(op),
				.u(u),
				.ring_in(ring[j]),
				.syn_word(syn[j])
			);
		end
	endgenerate

	// --------------------------------------------------
	// Assertions
	// --------------------------------------------------

	// A lone shift moves word 1 into word 0 and wraps word 0 to the top
	shift_rotates_bank: assert property (
		@(posedge clk) disable iff (!clrn)
		(shift && !init && !enable) |=>
			(syn[0] == $past(syn[1])) &&
			(syn[`RS_NUM_SYN-1] == $past(syn[0]))
	);

	// The bank leaves reset cleared
	reset_clears_bank: assert property (
		@(posedge clk)
		$rose(clrn) |-> (syn == '0)
	);

endmodule

/* testbench/rs_syn_model.svh */
// --------------------------------------------------
// Reference GF(2^8) arithmetic and expected syndromes
// --------------------------------------------------

`ifndef RS_SYN_MODEL_SVH
`define RS_SYN_MODEL_SVH

typedef logic [7:0] model_sym_t;
typedef logic [`RS_NUM_SYN-1:0][7:0] model_bank_t;

// Low byte of x^8+x^7+x^2+x+1
localparam logic [7:0] MODEL_POLY = 8'h87;

// Multiply by x and reduce when bit 7 falls out
function automatic model_sym_t xtime(input model_sym_t a);
	model_sym_t r;
	r = {a[6:0], 1'b0};
	if (a[7])
	begin
		r = r ^ MODEL_POLY;
	end
	return r;
endfunction

// Shift-and-add product of two field elements
function automatic model_sym_t field_mul(input model_sym_t a, input model_sym_t b);
	model_sym_t acc;
	model_sym_t x;
	model_sym_t y;
	acc = 8'h00;
	x = a;
	y = b;
	for (int i = 0; i < 8; i++)
	begin
		if (y[0])
			acc = acc ^ x;
		x = xtime(x);
		y = y >> 1;
	end
	return acc;
endfunction

// Power of alpha reduced by the group order 255
function automatic model_sym_t alpha_power(input int k);
	model_sym_t p;
	p = 8'h01;
	for (int i = 0; i < (k % 255); i++)
	begin
		p = xtime(p);
	end
	return p;
endfunction

// One Horner step S_j <- S_j * alpha^(j+1) + sym for every syndrome
function automatic model_bank_t horner_step(input model_bank_t bank, input model_sym_t sym);
	model_bank_t nxt;
	for (int j = 0; j < `RS_NUM_SYN; j++)
	begin
		nxt[j] = field_mul(bank[j], alpha_power(j + 1)) ^ sym;
	end
	return nxt;
endfunction

// A lone value e at position p from the end gives e * alpha^((j+1)p)
function automatic model_bank_t error_bank(input model_sym_t e, input int p);
	model_bank_t b;
	for (int j = 0; j < `RS_NUM_SYN; j++)
	begin
		b[j] = field_mul(e, alpha_power((j + 1) * p));
	end
	return b;
endfunction

// Bank after k shifts toward index 0
function automatic model_bank_t rotate_bank(input model_bank_t bank, input int k);
	model_bank_t r;
	for (int j = 0; j < `RS_NUM_SYN; j++)
	begin
		r[j] = bank[(j + k) % `RS_NUM_SYN];
	end
	return r;
endfunction

`endif

/* testbench/tb_rs_syndrome.sv */
// --------------------------------------------------
// Testbench for the RS syndrome generator
// --------------------------------------------------

`timescale 1ns/1ps

`include "rs_syn_consts.svh"

module tb_rs_syndrome;

	`include "rs_syn_model.svh"

	localparam int CLK_PERIOD = 8;
	localparam int NUM_ROWS = 10;
	localparam int MAX_LEN = 16;
	localparam int WATCHDOG_NS = (NUM_ROWS * 40 + 100) * CLK_PERIOD;

	// Row modes
	localparam int MODE_ACCUM = 0;
	localparam int MODE_GAP = 1;
	localparam int MODE_ROTATE = 2;

	// Error counter slots
	localparam int CHK_RESET = 0;
	localparam int CHK_BLOCK = 1;
	localparam int CHK_GAP = 2;
	localparam int CHK_PRIO = 3;
	localparam int CHK_ROTATE = 4;

	logic clk;
	logic clrn;
	logic [7:0] u;
	logic init;
	logic enable;
	logic shift;
	logic [`RS_NUM_SYN-1:0][7:0] syn;

	int row_count [NUM_ROWS];
	int row_start [NUM_ROWS];
	int row_pos [NUM_ROWS];
	int row_err [NUM_ROWS];
	int row_mode [NUM_ROWS];

	model_sym_t block_syms [MAX_LEN];
	model_bank_t exp_bank;
	logic [31:0] lcg_state;
	int err_count [5];
	int cur_row;
	int total_errors;

	rs_syndrome rs_syndrome_inst (
		.clk(clk),
		.clrn(clrn),
		.u(u),
		.init(init),
		.enable(enable),
		.shift(shift),
		.syn(syn)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// --------------------------------------------------
	// Helpers
	// --------------------------------------------------

	function automatic logic [7:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[23:16];
	endfunction

	task automatic set_row(input int idx, input int n, input int start, input int pos,
		input int err, input int mode);
		row_count[idx] = n;
		row_start[idx] = start;
		row_pos[idx] = pos;
		row_err[idx] = err;
		row_mode[idx] = mode;
	endtask

	// A zero start gives a sparse block and any other start a random tail
	task automatic fill_table();
		set_row(0, 1, 'h5a, 0, 'h00, MODE_ACCUM);
		set_row(1, 1, 'hff, 0, 'h00, MODE_ACCUM);
		set_row(2, 8, 'h3c, 0, 'h00, MODE_ACCUM);
		set_row(3, 12, 'h00, 5, 'h9d, MODE_ACCUM);
		set_row(4, 12, 'h00, 0, 'h01, MODE_ACCUM);
		set_row(5, 10, 'hc3, 3, 'h40, MODE_GAP);
		set_row(6, 7, 'h11, 0, 'h00, MODE_GAP);
		set_row(7, 5, 'ha7, 0, 'h00, MODE_ROTATE);
		set_row(8, 4, 'h00, 2, 'h77, MODE_ROTATE);
		set_row(9, 12, 'h01, 11, 'hee, MODE_ACCUM);
	endtask

	task automatic build_block(input int r);
		for (int i = 0; i < row_count[r]; i++)
		begin
			if (i == 0)
				block_syms[i] = row_start[r][7:0];
			else if (row_start[r] != 0)
				block_syms[i] = lcg_next();
			else
				block_syms[i] = 8'h00;
		end
		block_syms[row_count[r] - 1 - row_pos[r]] ^= row_err[r][7:0];
	endtask

	task automatic drive_cycle(input logic [7:0] sym, input logic s_init,
		input logic s_enable, input logic s_shift);
		@(posedge clk);
		u <= sym;
		init <= s_init;
		enable <= s_enable;
		shift <= s_shift;
	endtask

	// The lower priority strobes are raised as well when overlap is set
	task automatic send_block(input int n, input bit gaps, input bit overlap);
		for (int i = 0; i < n; i++)
		begin
			if (i == 0)
				drive_cycle(block_syms[i], 1'b1, overlap, overlap);
			else
				drive_cycle(block_syms[i], 1'b0, 1'b1, overlap);
			if (gaps && (i % 2 == 1) && (i < n - 1))
				drive_cycle(lcg_next(), 1'b0, 1'b0, 1'b0);
		end
		drive_cycle(8'h00, 1'b0, 1'b0, 1'b0);
		@(negedge clk);
	endtask

	task automatic check_bank(input model_bank_t want, input int kind);
		for (int j = 0; j < `RS_NUM_SYN; j++)
		begin
			assert (syn[j] === want[j])
			else
			begin
				$display("MISMATCH syn[%0d] row %0d: expected %h, actual %h",
					j, cur_row, want[j], syn[j]);
				err_count[kind] = err_count[kind] + 1;
			end
		end
	endtask

	// --------------------------------------------------
	// Watchdog
	// --------------------------------------------------

	initial
	begin
		#(WATCHDOG_NS);
		$display("Watchdog expired before all table rows were applied");
		$display("Verification failed");
		$finish;
	end

	// --------------------------------------------------
	// Main sequence
	// --------------------------------------------------

	initial
	begin
		clk = 1'b0;
		clrn <= 1'b0;
		u <= 8'h00;
		init <= 1'b0;
		enable <= 1'b0;
		shift <= 1'b0;
		lcg_state = 32'd72;
		cur_row = -1;
		for (int k = 0; k < 5; k++)
			err_count[k] = 0;
		fill_table();

		repeat (3) @(posedge clk);
		clrn <= 1'b1;
		@(negedge clk);
		check_bank('0, CHK_RESET);

		for (int r = 0; r < NUM_ROWS; r++)
		begin
			cur_row = r;
			build_block(r);
			if (row_start[r] == 0)
			begin
				exp_bank = error_bank(row_err[r][7:0], row_pos[r]);
			end
			else
			begin
				exp_bank = '0;
				for (int i = 0; i < row_count[r]; i++)
					exp_bank = horner_step(exp_bank, block_syms[i]);
			end

			case (row_mode[r])
				MODE_GAP:
				begin
					send_block(row_count[r], 1'b0, 1'b0);
					check_bank(exp_bank, CHK_BLOCK);
					send_block(row_count[r], 1'b1, 1'b0);
					check_bank(exp_bank, CHK_GAP);
				end
				MODE_ROTATE:
				begin
					send_block(row_count[r], 1'b0, 1'b1);
					check_bank(exp_bank, CHK_PRIO);
					drive_cycle(8'h00, 1'b0, 1'b0, 1'b1);
					for (int k = 1; k <= `RS_NUM_SYN; k++)
					begin
						drive_cycle(8'h00, 1'b0, 1'b0, k < `RS_NUM_SYN);
						@(negedge clk);
						check_bank(rotate_bank(exp_bank, k), CHK_ROTATE);
					end
				end
				default:
				begin
					send_block(row_count[r], 1'b0, 1'b0);
					check_bank(exp_bank, CHK_BLOCK);
				end
			endcase
		end

		total_errors = 0;
		for (int k = 0; k < 5; k++)
			total_errors = total_errors + err_count[k];
		$display("Errors: reset %0d, block %0d, gap %0d, priority %0d, rotate %0d",
			err_count[CHK_RESET], err_count[CHK_BLOCK], err_count[CHK_GAP],
			err_count[CHK_PRIO], err_count[CHK_ROTATE]);
		if (total_errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

/* rs_syndrome.f */
+incdir+verilog
+incdir+testbench
verilog/gf_pkg.sv
verilog/syn_pkg.sv
verilog/rs_syn_cell.sv
verilog/rs_syndrome.sv
testbench/tb_rs_syndrome.sv
